// ==== src/mdu_cfg.svh ====
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// datapath width, also the HI and LO width
`define MDU_XLEN 32

// one restoring step per quotient bit
`define MDU_DIV_STEPS 32

`endif

// ==== src/mdu_pkg.sv ====
`default_nettype none

`include "mdu_cfg.svh"

package mdu_pkg;

	// one-hot opcode, all zeros is no operation
	typedef logic [7:0] mdu_op_t;

	localparam int unsigned OP_MULT  = 0;
	localparam int unsigned OP_MULTU = 1;
	localparam int unsigned OP_DIV   = 2;
	localparam int unsigned OP_DIVU  = 3;
	localparam int unsigned OP_MFHI  = 4;
	localparam int unsigned OP_MFLO  = 5;
	localparam int unsigned OP_MTHI  = 6;
	localparam int unsigned OP_MTLO  = 7;

	// product, or MTHI/MTLO operand in its half
	typedef struct packed {
		logic [`MDU_XLEN-1:0] hi;
		logic [`MDU_XLEN-1:0] lo;
	} mdu_mul_view_t;

	// packed the way the divider returns it
	typedef struct packed {
		logic [`MDU_XLEN-1:0] quo;
		logic [`MDU_XLEN-1:0] rem;
	} mdu_div_view_t;

	typedef union packed {
		mdu_mul_view_t mul;
		mdu_div_view_t div;
	} mdu_wide_u;

endpackage

`default_nettype wire

// ==== src/mdu_decode.sv ====
`default_nettype none

`include "mdu_cfg.svh"

module mdu_decode (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire                   stall_i,
	input  wire                   flush_i,
	input  wire                   hold_i,
	input  mdu_pkg::mdu_op_t      op_i,
	input  wire [`MDU_XLEN-1:0]   opr1_i,
	input  wire [`MDU_XLEN-1:0]   opr2_i,
	output logic                  valid_o,
	output mdu_pkg::mdu_op_t      op_o,
	output logic [1:0]            res_sign_o,
	output logic [`MDU_XLEN-1:0]  mag1_o,
	output logic [`MDU_XLEN-1:0]  mag2_o,
	output logic [`MDU_XLEN-1:0]  raw_o,
	output logic [`MDU_XLEN-1:0]  pp_ac_o,
	output logic [`MDU_XLEN-1:0]  pp_ad_o,
	output logic [`MDU_XLEN-1:0]  pp_cb_o,
	output logic [`MDU_XLEN-1:0]  pp_bd_o
);

	import mdu_pkg::*;

	localparam int XLEN = `MDU_XLEN;
	localparam int HALF = XLEN / 2;

	logic            is_signed;
	logic            neg1;
	logic            neg2;
	logic [XLEN-1:0] mag1;
	logic [XLEN-1:0] mag2;
	logic [1:0]      res_sign;
	logic            load;

	always_comb begin
		is_signed = op_i[OP_MULT] | op_i[OP_DIV];
		neg1 = is_signed & opr1_i[XLEN-1];
		neg2 = is_signed & opr2_i[XLEN-1];
		mag1 = neg1 ? -opr1_i : opr1_i;
		mag2 = neg2 ? -opr2_i : opr2_i;
		// [1] product or quotient sign, [0] remainder follows dividend
		res_sign[1] = neg1 ^ neg2;
		res_sign[0] = op_i[OP_DIV] & neg1;
	end

	assign load = ~stall_i & ~hold_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			op_o    <= '0;
		end else if (flush_i) begin
			valid_o <= 1'b0;
		end else if (load) begin
			valid_o <= |op_i;
			op_o    <= op_i;
		end
	end

	// operands split as {a,b} x {c,d}
	always_ff @(posedge clk) begin
		if (load) begin
			res_sign_o <= res_sign;
			mag1_o     <= mag1;
			mag2_o     <= mag2;
			raw_o      <= opr1_i;
			pp_ac_o    <= XLEN'(mag1[XLEN-1:HALF]) * XLEN'(mag2[XLEN-1:HALF]);
			pp_ad_o    <= XLEN'(mag1[XLEN-1:HALF]) * XLEN'(mag2[HALF-1:0]);
			pp_cb_o    <= XLEN'(mag2[XLEN-1:HALF]) * XLEN'(mag1[HALF-1:0]);
			pp_bd_o    <= XLEN'(mag1[HALF-1:0]) * XLEN'(mag2[HALF-1:0]);
		end
	end

endmodule

`default_nettype wire

// ==== src/mdu_execute.sv ====
`default_nettype none

`include "mdu_cfg.svh"

module mdu_execute (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire                   stall_i,
	input  wire                   flush_i,
	input  wire                   valid_i,
	input  mdu_pkg::mdu_op_t      op_i,
	input  wire [1:0]             res_sign_i,
	input  wire [`MDU_XLEN-1:0]   mag1_i,
	input  wire [`MDU_XLEN-1:0]   mag2_i,
	input  wire [`MDU_XLEN-1:0]   raw_i,
	input  wire [`MDU_XLEN-1:0]   pp_ac_i,
	input  wire [`MDU_XLEN-1:0]   pp_ad_i,
	input  wire [`MDU_XLEN-1:0]   pp_cb_i,
	input  wire [`MDU_XLEN-1:0]   pp_bd_i,
	input  wire                   div_done_i,
	input  mdu_pkg::mdu_wide_u    div_result_i,
	output logic                  busy_o,
	output logic                  div_start_o,
	output logic [`MDU_XLEN-1:0]  div_dividend_o,
	output logic [`MDU_XLEN-1:0]  div_divisor_o,
	output logic                  valid_o,
	output mdu_pkg::mdu_op_t      op_o,
	output mdu_pkg::mdu_wide_u    wide_o
);

	import mdu_pkg::*;

	localparam int XLEN = `MDU_XLEN;
	localparam int HALF = XLEN / 2;

	logic              is_div;
	logic [2*XLEN-1:0] mid;
	logic [2*XLEN-1:0] prod_mag;
	logic [2*XLEN-1:0] prod;
	mdu_wide_u         next_wide;
	mdu_wide_u         div_wide;

	logic              valid_q;
	logic              busy_q;
	logic              start_q;
	mdu_op_t           op_q;
	mdu_wide_u         wide_q;
	logic [1:0]        sign_q;
	logic [XLEN-1:0]   dividend_q;
	logic [XLEN-1:0]   divisor_q;

	assign is_div = op_i[OP_DIV] | op_i[OP_DIVU];

	// ac<<32 + (ad+cb)<<16 + bd
	always_comb begin
		mid = ({{XLEN{1'b0}}, pp_ad_i} + {{XLEN{1'b0}}, pp_cb_i}) << HALF;
		prod_mag = {pp_ac_i, pp_bd_i} + mid;
		prod = res_sign_i[1] ? -prod_mag : prod_mag;
	end

	always_comb begin
		next_wide = '0;
		if (op_i[OP_MULT] | op_i[OP_MULTU])
			next_wide = prod;
		else if (op_i[OP_MTHI])
			next_wide.mul.hi = raw_i;
		else if (op_i[OP_MTLO])
			next_wide.mul.lo = raw_i;
	end

	// unsigned divider result back to signed
	always_comb begin
		div_wide.div.quo = sign_q[1] ? -div_result_i.div.quo : div_result_i.div.quo;
		div_wide.div.rem = sign_q[0] ? -div_result_i.div.rem : div_result_i.div.rem;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
			busy_q  <= 1'b0;
			start_q <= 1'b0;
			op_q    <= '0;
		end else if (flush_i) begin
			valid_q <= 1'b0;
			busy_q  <= 1'b0;
			start_q <= 1'b0;
		end else if (!stall_i) begin
			start_q <= 1'b0;
			if (busy_q) begin
				if (div_done_i)
					busy_q <= 1'b0;
			end else begin
				op_q    <= op_i;
				valid_q <= valid_i & ~is_div;
				busy_q  <= valid_i & is_div;
				start_q <= valid_i & is_div;
			end
		end
	end

	// divide operands stay put while the divider runs
	always_ff @(posedge clk) begin
		if (!stall_i && !busy_q) begin
			wide_q     <= next_wide;
			sign_q     <= res_sign_i;
			dividend_q <= mag1_i;
			divisor_q  <= mag2_i;
		end
	end

	assign busy_o         = busy_q;
	assign div_start_o    = start_q;
	assign div_dividend_o = dividend_q;
	assign div_divisor_o  = divisor_q;
	assign op_o           = op_q;
	assign valid_o        = (valid_q | (busy_q & div_done_i)) & ~flush_i;
	assign wide_o         = busy_q ? div_wide : wide_q;

endmodule

`default_nettype wire

// ==== src/mdu_divider.sv ====
`default_nettype none

`include "mdu_cfg.svh"

module mdu_divider (
	input  wire                     clk,
	input  wire                     rst_n_i,
	input  wire                     stall_i,
	input  wire                     flush_i,
	input  wire                     start_i,
	input  wire [`MDU_XLEN-1:0]     dividend_i,
	input  wire [`MDU_XLEN-1:0]     divisor_i,
	output logic                    done_o,
	output logic [2*`MDU_XLEN-1:0]  result_o
);

	localparam int XLEN  = `MDU_XLEN;
	localparam int CNT_W = $clog2(`MDU_DIV_STEPS + 1);

	logic             run_q;
	logic             done_q;
	logic [CNT_W-1:0] cnt_q;
	logic [XLEN-1:0]  quo_q;
	logic [XLEN-1:0]  rem_q;
	logic [XLEN-1:0]  dvs_q;

	logic [XLEN:0]    shifted;
	logic [XLEN:0]    diff;
	logic             fits;

	// partial remainder with next dividend bit shifted in
	always_comb begin
		shifted = {rem_q, quo_q[XLEN-1]};
		diff    = shifted - {1'b0, dvs_q};
		fits    = shifted >= {1'b0, dvs_q};
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			run_q  <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else if (flush_i) begin
			run_q  <= 1'b0;
			done_q <= 1'b0;
		end else if (!stall_i) begin
			done_q <= 1'b0;
			if (start_i) begin
				run_q <= 1'b1;
				cnt_q <= '0;
			end else if (run_q) begin
				cnt_q <= cnt_q + 1'b1;
				if (cnt_q == CNT_W'(`MDU_DIV_STEPS - 1)) begin
					run_q  <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			if (start_i) begin
				quo_q <= dividend_i;
				rem_q <= '0;
				dvs_q <= divisor_i;
			end else if (run_q) begin
				// restore on a failed subtract
				rem_q <= fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
				quo_q <= {quo_q[XLEN-2:0], fits};
			end
		end
	end

	assign done_o   = done_q;
	assign result_o = {quo_q, rem_q};

endmodule

`default_nettype wire

// ==== src/mdu_result.sv ====
`default_nettype none

`include "mdu_cfg.svh"

module mdu_result (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire                   stall_i,
	input  wire                   valid_i,
	input  mdu_pkg::mdu_op_t      op_i,
	input  mdu_pkg::mdu_wide_u    wide_i,
	output logic [`MDU_XLEN-1:0]  hi_o,
	output logic [`MDU_XLEN-1:0]  lo_o,
	output logic                  rd_valid_o,
	output logic [`MDU_XLEN-1:0]  rd_data_o
);

	import mdu_pkg::*;

	logic                 is_mul;
	logic                 is_div;
	logic                 is_mf;
	logic                 wr_hi;
	logic                 wr_lo;
	logic [`MDU_XLEN-1:0] hi_next;
	logic [`MDU_XLEN-1:0] lo_next;

	always_comb begin
		is_mul = op_i[OP_MULT] | op_i[OP_MULTU];
		is_div = op_i[OP_DIV] | op_i[OP_DIVU];
		is_mf  = op_i[OP_MFHI] | op_i[OP_MFLO];
		wr_hi  = valid_i & ~stall_i & (is_mul | is_div | op_i[OP_MTHI]);
		wr_lo  = valid_i & ~stall_i & (is_mul | is_div | op_i[OP_MTLO]);
		// HI takes the remainder, LO the quotient
		hi_next = is_div ? wide_i.div.rem : wide_i.mul.hi;
		lo_next = is_div ? wide_i.div.quo : wide_i.mul.lo;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			hi_o       <= '0;
			lo_o       <= '0;
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= valid_i & ~stall_i & is_mf;
			if (wr_hi)
				hi_o <= hi_next;
			if (wr_lo)
				lo_o <= lo_next;
		end
	end

	// MF reads the value written at the previous edge
	always_ff @(posedge clk) begin
		if (valid_i && !stall_i && is_mf)
			rd_data_o <= op_i[OP_MFHI] ? hi_o : lo_o;
	end

endmodule

`default_nettype wire

// ==== src/mdu_top.sv ====
`default_nettype none

`include "mdu_cfg.svh"

module mdu_top (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  mdu_pkg::mdu_op_t      op_i,
	input  wire [`MDU_XLEN-1:0]   opr1_i,
	input  wire [`MDU_XLEN-1:0]   opr2_i,
	input  wire                   stall_i,
	input  wire                   flush_i,
	output logic                  busy_o,
	output logic [`MDU_XLEN-1:0]  hi_o,
	output logic [`MDU_XLEN-1:0]  lo_o,
	output logic                  rd_valid_o,
	output logic [`MDU_XLEN-1:0]  rd_data_o
);

	import mdu_pkg::*;

	logic                   dec_valid;
	mdu_op_t                dec_op;
	logic [1:0]             dec_res_sign;
	logic [`MDU_XLEN-1:0]   dec_mag1;
	logic [`MDU_XLEN-1:0]   dec_mag2;
	logic [`MDU_XLEN-1:0]   dec_raw;
	logic [`MDU_XLEN-1:0]   dec_pp_ac;
	logic [`MDU_XLEN-1:0]   dec_pp_ad;
	logic [`MDU_XLEN-1:0]   dec_pp_cb;
	logic [`MDU_XLEN-1:0]   dec_pp_bd;

	logic                   div_start;
	logic [`MDU_XLEN-1:0]   div_dividend;
	logic [`MDU_XLEN-1:0]   div_divisor;
	logic                   div_done;
	logic [2*`MDU_XLEN-1:0] div_result;

	logic                   exe_valid;
	mdu_op_t                exe_op;
	mdu_wide_u              exe_wide;

	// decode holds while a divide is in flight
	mdu_decode u_decode (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.stall_i    (stall_i),
		.flush_i    (flush_i),
		.hold_i     (busy_o),
		.op_i       (op_i),
		.opr1_i     (opr1_i),
		.opr2_i     (opr2_i),
		.valid_o    (dec_valid),
		.op_o       (dec_op),
		.res_sign_o (dec_res_sign),
		.mag1_o     (dec_mag1),
		.mag2_o     (dec_mag2),
		.raw_o      (dec_raw),
		.pp_ac_o    (dec_pp_ac),
		.pp_ad_o    (dec_pp_ad),
		.pp_cb_o    (dec_pp_cb),
		.pp_bd_o    (dec_pp_bd)
	);

	mdu_execute u_execute (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.stall_i        (stall_i),
		.flush_i        (flush_i),
		.valid_i        (dec_valid),
		.op_i           (dec_op),
		.res_sign_i     (dec_res_sign),
		.mag1_i         (dec_mag1),
		.mag2_i         (dec_mag2),
		.raw_i          (dec_raw),
		.pp_ac_i        (dec_pp_ac),
		.pp_ad_i        (dec_pp_ad),
		.pp_cb_i        (dec_pp_cb),
		.pp_bd_i        (dec_pp_bd),
		.div_done_i     (div_done),
		.div_result_i   (div_result),
		.busy_o         (busy_o),
		.div_start_o    (div_start),
		.div_dividend_o (div_dividend),
		.div_divisor_o  (div_divisor),
		.valid_o        (exe_valid),
		.op_o           (exe_op),
		.wide_o         (exe_wide)
	);

	mdu_divider u_divider (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.stall_i    (stall_i),
		.flush_i    (flush_i),
		.start_i    (div_start),
		.dividend_i (div_dividend),
		.divisor_i  (div_divisor),
		.done_o     (div_done),
		.result_o   (div_result)
	);

	mdu_result u_result (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.stall_i    (stall_i),
		.valid_i    (exe_valid),
		.op_i       (exe_op),
		.wide_i     (exe_wide),
		.hi_o       (hi_o),
		.lo_o       (lo_o),
		.rd_valid_o (rd_valid_o),
		.rd_data_o  (rd_data_o)
	);

endmodule

`default_nettype wire

// ==== bench/mdu_properties.sv ====
`default_nettype none

`include "mdu_cfg.svh"

module mdu_properties (
	input wire              clk,
	input wire              rst_n_i,
	input mdu_pkg::mdu_op_t op_i,
	input wire              stall_i,
	input wire              flush_i,
	input wire              busy_i,
	input wire              rd_valid_i
);

	import mdu_pkg::*;

	localparam int BUSY_MAX = `MDU_DIV_STEPS + 4;

	logic mf_accept;
	int   mf_pending;
	int   busy_run;

	assign mf_accept = (op_i[OP_MFHI] | op_i[OP_MFLO]) & ~stall_i & ~busy_i & ~flush_i;

	// MF ops accepted but not yet returned
	always_ff @(posedge clk) begin
		if (!rst_n_i || flush_i)
			mf_pending <= 0;
		else
			mf_pending <= mf_pending + int'(mf_accept) - int'(rd_valid_i);
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i || !busy_i)
			busy_run <= 0;
		else
			busy_run <= busy_run + 1;
	end

	a_reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !busy_i && !rd_valid_i)
		else $error("busy or read valid set right after reset");

	a_busy_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
		busy_i |-> busy_run < BUSY_MAX)
		else $error("busy held longer than a divide takes");

	// a second pulse needs a second MF
	a_rd_single: assert property (@(posedge clk) disable iff (!rst_n_i)
		rd_valid_i |-> mf_pending > 0)
		else $error("read valid without an outstanding MF op");

endmodule

`default_nettype wire

// ==== bench/mdu_tb.sv ====
`default_nettype none

`include "mdu_cfg.svh"

module mdu_tb;

	import mdu_pkg::*;

	localparam int XLEN = `MDU_XLEN;
	// about 220 ops at under 40 cycles each, rounded up
	localparam int TIMEOUT_CYCLES = 10000;

	logic            clk;
	logic            rst_n_i;
	mdu_op_t         op_i;
	logic [XLEN-1:0] opr1_i;
	logic [XLEN-1:0] opr2_i;
	logic            stall_i;
	logic            flush_i;
	logic            busy_o;
	logic [XLEN-1:0] hi_o;
	logic [XLEN-1:0] lo_o;
	logic            rd_valid_o;
	logic [XLEN-1:0] rd_data_o;

	int              seed;
	int              errors;
	int              checks;
	int              err_mark;
	int              tests_run;
	int              tests_failed;
	int              cycle_cnt;
	string           cur_test;
	logic [XLEN-1:0] model_hi;
	logic [XLEN-1:0] model_lo;
	logic [XLEN-1:0] rd_exp_q[$];
	logic [XLEN-1:0] hi_exp_q[$];
	logic [XLEN-1:0] lo_exp_q[$];
	event            op_done;

	mdu_top u_dut (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.op_i       (op_i),
		.opr1_i     (opr1_i),
		.opr2_i     (opr2_i),
		.stall_i    (stall_i),
		.flush_i    (flush_i),
		.busy_o     (busy_o),
		.hi_o       (hi_o),
		.lo_o       (lo_o),
		.rd_valid_o (rd_valid_o),
		.rd_data_o  (rd_data_o)
	);

	bind mdu_top mdu_properties u_props (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.op_i       (op_i),
		.stall_i    (stall_i),
		.flush_i    (flush_i),
		.busy_i     (busy_o),
		.rd_valid_i (rd_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	task automatic check(input string what, input logic [XLEN-1:0] exp,
			input logic [XLEN-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("** Error %s: %s expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	// HI/LO model, returns MFHI/MFLO read data
	function automatic logic [XLEN-1:0] ref_mdu(input mdu_op_t op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		longint            sa;
		longint            sb;
		longint            sq;
		longint            sr;
		logic [2*XLEN-1:0] prod;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		if (op[OP_MULT] || op[OP_MULTU]) begin
			if (op[OP_MULT])
				prod = sa * sb;
			else
				prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
			model_hi = prod[2*XLEN-1:XLEN];
			model_lo = prod[XLEN-1:0];
		end else if (op[OP_DIV]) begin
			// 64-bit math so -2^31 / -1 wraps instead of trapping
			sq = sa / sb;
			sr = sa % sb;
			model_lo = sq[XLEN-1:0];
			model_hi = sr[XLEN-1:0];
		end else if (op[OP_DIVU]) begin
			model_lo = a / b;
			model_hi = a % b;
		end else if (op[OP_MTHI]) begin
			model_hi = a;
		end else if (op[OP_MTLO]) begin
			model_lo = a;
		end
		return op[OP_MFHI] ? model_hi : model_lo;
	endfunction

	function automatic mdu_op_t onehot(input int unsigned bit_pos);
		mdu_op_t op;
		op = '0;
		op[bit_pos] = 1'b1;
		return op;
	endfunction

	// edge values show up often
	function automatic logic [XLEN-1:0] rand_operand();
		int unsigned pick;
		pick = $unsigned($random(seed)) % 8;
		case (pick)
			0: return 32'h8000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h7fff_ffff;
			3: return 32'h0000_0001;
			default: return $random(seed);
		endcase
	endfunction

	function automatic logic [XLEN-1:0] rand_divisor();
		logic [XLEN-1:0] d;
		d = rand_operand();
		while (d == '0)
			d = rand_operand();
		return d;
	endfunction

	// one op for one cycle, starting on a falling edge
	task automatic drive_op(input mdu_op_t op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		logic [XLEN-1:0] rd;
		rd = ref_mdu(op, a, b);
		if (op[OP_MFHI] || op[OP_MFLO])
			rd_exp_q.push_back(rd);
		op_i   = op;
		opr1_i = a;
		opr2_i = b;
		@(negedge clk);
	endtask

	task automatic expect_hilo();
		hi_exp_q.push_back(model_hi);
		lo_exp_q.push_back(model_lo);
		-> op_done;
	endtask

	task automatic issue(input mdu_op_t op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		int   waited;
		logic seen_busy;
		drive_op(op, a, b);
		op_i = '0;
		if (op[OP_DIV] || op[OP_DIVU]) begin
			@(negedge clk);
			seen_busy = busy_o;
			waited    = 0;
			while (busy_o && waited < `MDU_DIV_STEPS + 8) begin
				@(negedge clk);
				waited++;
			end
			if (!seen_busy) begin
				errors++;
				$display("%s: busy_o never went high for a divide", cur_test);
			end
			if (busy_o) begin
				errors++;
				$display("%s: busy_o still high %0d cycles into a divide", cur_test, waited);
			end
		end else begin
			repeat (2) @(negedge clk);
		end
		expect_hilo();
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_mark = errors;
	endtask

	task automatic finish_test();
		repeat (2) @(negedge clk);
		tests_run++;
		if (errors != err_mark)
			tests_failed++;
		$display("test %-12s %s, %0d errors", cur_test,
			(errors == err_mark) ? "ok" : "FAILED", errors - err_mark);
	endtask

	// compare read data as it comes back
	always @(negedge clk) begin
		if (rst_n_i && rd_valid_o) begin
			if (rd_exp_q.size() == 0) begin
				errors++;
				$display("%s: rd_valid_o pulsed with no MF op outstanding", cur_test);
			end else begin
				check("rd_data_o", rd_exp_q.pop_front(), rd_data_o);
			end
		end
	end

	always @(op_done) begin
		check("hi_o", hi_exp_q.pop_front(), hi_o);
		check("lo_o", lo_exp_q.pop_front(), lo_o);
	end

	initial begin
		int              i;
		mdu_op_t         op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] old_hi;
		logic [XLEN-1:0] old_lo;
		int unsigned     stall_len;
		logic            at_exe;

		seed         = 32'h868a;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		model_hi     = '0;
		model_lo     = '0;
		rst_n_i      = 1'b0;
		op_i         = '0;
		opr1_i       = '0;
		opr2_i       = '0;
		stall_i      = 1'b0;
		flush_i      = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;

		start_test("reset");
		check("hi_o", '0, hi_o);
		check("lo_o", '0, lo_o);
		check("busy_o", '0, XLEN'(busy_o));
		check("rd_valid_o", '0, XLEN'(rd_valid_o));
		finish_test();

		start_test("move");
		for (i = 0; i < 10; i++) begin
			a = $random(seed);
			b = $random(seed);
			issue(onehot(OP_MTHI), a, '0);
			issue(onehot(OP_MTLO), b, '0);
			issue(onehot(OP_MFHI), '0, '0);
			issue(onehot(OP_MFLO), '0, '0);
		end
		finish_test();

		start_test("multiply");
		for (i = 0; i < 60; i++) begin
			op = (($random(seed) & 1) != 0) ? onehot(OP_MULT) : onehot(OP_MULTU);
			issue(op, rand_operand(), rand_operand());
		end
		finish_test();

		start_test("divide");
		issue(onehot(OP_DIV), 32'h8000_0000, 32'hffff_ffff);
		for (i = 0; i < 59; i++) begin
			op = (($random(seed) & 1) != 0) ? onehot(OP_DIV) : onehot(OP_DIVU);
			issue(op, rand_operand(), rand_divisor());
		end
		finish_test();

		start_test("back_to_back");
		for (i = 0; i < 4; i++) begin
			drive_op(onehot(OP_MULT), rand_operand(), rand_operand());
			drive_op(onehot(OP_MFHI), '0, '0);
			drive_op(onehot(OP_MFLO), '0, '0);
			op_i = '0;
			@(negedge clk);
			check("rd_valid_o", XLEN'(1), XLEN'(rd_valid_o));
			@(negedge clk);
			check("rd_valid_o", XLEN'(1), XLEN'(rd_valid_o));
			expect_hilo();
		end
		finish_test();

		start_test("stall_flush");
		for (i = 0; i < 8; i++) begin
			stall_len = 1 + $unsigned($random(seed)) % 5;
			at_exe    = ($random(seed) & 1) != 0;
			old_hi    = model_hi;
			old_lo    = model_lo;
			drive_op(onehot(OP_MULT), rand_operand(), rand_operand());
			op_i = '0;
			if (at_exe)
				@(negedge clk);
			stall_i = 1'b1;
			repeat (stall_len) @(negedge clk);
			// nothing written while held
			check("hi_o", old_hi, hi_o);
			check("lo_o", old_lo, lo_o);
			stall_i = 1'b0;
			repeat (at_exe ? 1 : 2) @(negedge clk);
			expect_hilo();
		end
		// flushed divide never reaches the model
		op_i   = onehot(OP_DIV);
		opr1_i = rand_operand();
		opr2_i = rand_divisor();
		@(negedge clk);
		op_i = '0;
		@(negedge clk);
		check("busy_o", XLEN'(1), XLEN'(busy_o));
		repeat (1 + $unsigned($random(seed)) % 20) @(negedge clk);
		flush_i = 1'b1;
		@(negedge clk);
		flush_i = 1'b0;
		check("busy_o", '0, XLEN'(busy_o));
		repeat (`MDU_DIV_STEPS + 4) @(negedge clk);
		expect_hilo();
		issue(onehot(OP_MULT), rand_operand(), rand_operand());
		finish_test();

		if (rd_exp_q.size() != 0) begin
			errors++;
			$display("%0d MF reads never returned data", rd_exp_q.size());
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/mdu_pkg.sv
src/mdu_decode.sv
src/mdu_execute.sv
src/mdu_divider.sv
src/mdu_result.sv
src/mdu_top.sv
bench/mdu_properties.sv
bench/mdu_tb.sv

// ==== Makefile ====
BIN = obj_dir/Vmdu_tb

.PHONY: all run clean

all: run

$(BIN): list.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --assert --top-module mdu_tb -f list.f

run: $(BIN)
	$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
